// File: mem_cfg.svh
`ifndef MEM_CFG_SVH
`define MEM_CFG_SVH

// bus address width.
`define ADDR_W 64

// width of one data word, which is also one cache line.
`define WORD_W 64

`define INDEX_W 5    // 32 lines.
`define CTAG_W 8     // tag bits kept per line.

// memory transaction tag, zero is reserved for "no tag".
`define MEM_TAG_W 4

`define OFFSET_W 3   // byte offset inside a line.

`endif

// File: bus_pkg.sv
`default_nettype none

`include "mem_cfg.svh"

package bus_pkg;

  typedef logic [`ADDR_W-1:0] addr_t;

  typedef logic [`WORD_W-1:0] word_t;

  // a zero tag means the command was refused or no data is returning.
  typedef logic [`MEM_TAG_W-1:0] mem_tag_t;

  typedef enum logic [1:0] {
    bus_none  = 2'h0,
    bus_load  = 2'h1,
    bus_store = 2'h2
  } bus_command_t;

endpackage

`default_nettype wire

// File: icache_pkg.sv
`default_nettype none

`include "mem_cfg.svh"

package icache_pkg;

  // selects one of the direct-mapped lines.
  typedef logic [`INDEX_W-1:0] cache_index_t;

  // upper line address bits stored beside each line.
  typedef logic [`CTAG_W-1:0] cache_tag_t;

endpackage

`default_nettype wire

// File: icache_ctrl.sv
`default_nettype none

`include "mem_cfg.svh"

module icache_ctrl (
  input  wire logic                clock,
  input  wire logic                reset,
  input  wire bus_pkg::addr_t      fetch_addr,
  input  wire bus_pkg::mem_tag_t   mem_response,
  input  wire bus_pkg::mem_tag_t   mem_tag,
  input  wire logic                cachemem_valid,
  output bus_pkg::bus_command_t    fetch_command,
  output bus_pkg::addr_t           fetch_mem_addr,
  output icache_pkg::cache_index_t current_index,
  output icache_pkg::cache_tag_t   current_tag,
  output logic                     data_write_enable,
  output logic                     fetch_valid
);

  import bus_pkg::*;
  import icache_pkg::*;

  logic [`CTAG_W+`INDEX_W-1:0] line_addr;
  cache_index_t                last_index;
  cache_tag_t                  last_tag;
  mem_tag_t                    pending_tag;
  logic                        miss_outstanding;
  logic                        changed_addr;
  logic                        update_tag;
  logic                        unanswered_miss;

  assign line_addr = fetch_addr[`OFFSET_W+`INDEX_W+`CTAG_W-1:`OFFSET_W];
  assign {current_tag, current_index} = line_addr;

  assign changed_addr = (current_index != last_index) || (current_tag != last_tag);

  assign fetch_mem_addr = {fetch_addr[`ADDR_W-1:`OFFSET_W], {`OFFSET_W{1'b0}}};
  assign fetch_command  = (miss_outstanding && !changed_addr) ? bus_load : bus_none;

  // a return that lands as the address moves belongs to the old line.
  assign data_write_enable = (pending_tag == mem_tag) && (pending_tag != '0) && !changed_addr;

  assign fetch_valid = cachemem_valid;

  // the held tag is replaced on a new address, which drops any older load.
  assign update_tag = changed_addr || miss_outstanding || data_write_enable;

  assign unanswered_miss = changed_addr ? !cachemem_valid
                                        : miss_outstanding && (mem_response == '0);

  always_ff @(posedge clock) begin
    if (reset) begin
      last_index       <= '1;  // all ones so the first fetch looks like a new address.
      last_tag         <= '1;
      pending_tag      <= '0;
      miss_outstanding <= 1'b0;
    end else begin
      last_index       <= current_index;
      last_tag         <= current_tag;
      miss_outstanding <= unanswered_miss;
      if (update_tag) begin
        pending_tag <= mem_response;
      end
    end
  end

  // a new line address is looked up first, the load can only follow a cycle later.
  assert property (@(posedge clock) disable iff (reset)
    (line_addr != $past(line_addr)) |-> (fetch_command != bus_load));

endmodule

`default_nettype wire

// File: icache_mem.sv
`default_nettype none

`include "mem_cfg.svh"

module icache_mem (
  input  wire logic                     clock,
  input  wire logic                     reset,
  input  wire icache_pkg::cache_index_t current_index,
  input  wire icache_pkg::cache_tag_t   current_tag,
  input  wire logic                     data_write_enable,
  input  wire bus_pkg::word_t           mem_data,
  output bus_pkg::word_t                cachemem_data,
  output logic                          cachemem_valid
);

  import bus_pkg::*;
  import icache_pkg::*;

  word_t                    line_data [(1 << `INDEX_W)];
  cache_tag_t               line_tag  [(1 << `INDEX_W)];
  logic [(1 << `INDEX_W)-1:0] line_valid;

  always_ff @(posedge clock) begin
    if (reset) begin
      line_valid <= '0;
    end else if (data_write_enable) begin
      line_valid[current_index] <= 1'b1;
    end
  end

  // a write simply overwrites the slot, so a line with another tag is evicted.
  always_ff @(posedge clock) begin
    if (data_write_enable) begin
      line_data[current_index] <= mem_data;
      line_tag[current_index]  <= current_tag;
    end
  end

  assign cachemem_data = line_data[current_index];

  // the tag compare keeps a conflicting line from answering.
  assign cachemem_valid = line_valid[current_index] &&
                          (line_tag[current_index] == current_tag);

endmodule

`default_nettype wire

// File: bus_arbiter.sv
`default_nettype none

`include "mem_cfg.svh"

module bus_arbiter (
  input  wire bus_pkg::bus_command_t fetch_command,
  input  wire bus_pkg::addr_t        fetch_mem_addr,
  input  wire bus_pkg::bus_command_t data_command,
  input  wire bus_pkg::addr_t        data_mem_addr,
  input  wire bus_pkg::word_t        data_mem_wdata,
  input  wire bus_pkg::mem_tag_t     mem_response,
  output bus_pkg::bus_command_t      mem_command,
  output bus_pkg::addr_t             mem_addr,
  output bus_pkg::word_t             mem_wdata,
  output bus_pkg::mem_tag_t          fetch_response,
  output bus_pkg::mem_tag_t          data_response
);

  import bus_pkg::*;

  logic data_grant;

  always_comb begin
    data_grant = (data_command != bus_none);  // the data port always wins.

    if (data_grant) begin
      mem_command    = data_command;
      mem_addr       = data_mem_addr;
      mem_wdata      = data_mem_wdata;
      data_response  = mem_response;
      fetch_response = '0;  // the fetch side sees a refusal and retries.
    end else begin
      mem_command    = fetch_command;
      mem_addr       = fetch_mem_addr;
      mem_wdata      = '0;
      data_response  = '0;
      fetch_response = mem_response;
    end

    assert (!((fetch_response != '0) && (data_response != '0)));
  end

endmodule

`default_nettype wire

// File: data_port.sv
`default_nettype none

`include "mem_cfg.svh"

module data_port (
  input  wire logic                  clock,
  input  wire logic                  reset,
  input  wire logic                  data_req,
  input  wire bus_pkg::bus_command_t data_command_in,
  input  wire bus_pkg::addr_t        data_addr,
  input  wire bus_pkg::word_t        data_wdata,
  input  wire bus_pkg::mem_tag_t     data_response,
  input  wire bus_pkg::mem_tag_t     mem_tag,
  input  wire bus_pkg::word_t        mem_data,
  output bus_pkg::bus_command_t      data_command,
  output bus_pkg::addr_t             data_mem_addr,
  output bus_pkg::word_t             data_mem_wdata,
  output bus_pkg::word_t             data_rdata,
  output logic                       data_done
);

  import bus_pkg::*;

  typedef enum logic [1:0] {
    idle,
    issue,
    wait_data
  } port_state_t;

  port_state_t state;
  mem_tag_t    held_tag;
  logic        load_return;

  assign data_command   = (state == issue) ? data_command_in : bus_none;
  assign data_mem_addr  = {data_addr[`ADDR_W-1:`OFFSET_W], {`OFFSET_W{1'b0}}};
  assign data_mem_wdata = data_wdata;

  assign load_return = (state == wait_data) && (mem_tag == held_tag);

  always_ff @(posedge clock) begin
    if (reset) begin
      state     <= idle;
      held_tag  <= '0;
      data_done <= 1'b0;
    end else begin
      data_done <= 1'b0;
      case (state)
        idle: begin
          if (data_req && !data_done) begin  // the done cycle is not a new request.
            state <= issue;
          end
        end
        issue: begin
          if (data_response != '0) begin
            if (data_command_in == bus_store) begin
              data_done <= 1'b1;  // a store is finished once accepted.
              state     <= idle;
            end else begin
              held_tag <= data_response;
              state    <= wait_data;
            end
          end
        end
        wait_data: begin
          if (load_return) begin
            data_done <= 1'b1;
            held_tag  <= '0;
            state     <= idle;
          end
        end
        default: state <= idle;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (load_return) begin
      data_rdata <= mem_data;
    end
  end

  // the requester keeps its level up until the access has completed.
  assert property (@(posedge clock) disable iff (reset)
    $fell(data_req) |-> data_done);

endmodule

`default_nettype wire

// File: fetch_mem_top.sv
`default_nettype none

`include "mem_cfg.svh"

module fetch_mem_top (
  input  wire logic                  clock,
  input  wire logic                  reset,
  input  wire bus_pkg::addr_t        fetch_addr,
  input  wire logic                  data_req,
  input  wire bus_pkg::bus_command_t data_command_in,
  input  wire bus_pkg::addr_t        data_addr,
  input  wire bus_pkg::word_t        data_wdata,
  input  wire bus_pkg::mem_tag_t     mem_response,
  input  wire bus_pkg::mem_tag_t     mem_tag,
  input  wire bus_pkg::word_t        mem_data,
  output bus_pkg::word_t             fetch_data,
  output logic                       fetch_valid,
  output bus_pkg::word_t             data_rdata,
  output logic                       data_done,
  output bus_pkg::bus_command_t      mem_command,
  output bus_pkg::addr_t             mem_addr,
  output bus_pkg::word_t             mem_wdata
);

  import bus_pkg::*;
  import icache_pkg::*;

  bus_command_t fetch_command;
  bus_command_t data_command;
  addr_t        fetch_mem_addr;
  addr_t        data_mem_addr;
  word_t        data_mem_wdata;
  word_t        cachemem_data;
  mem_tag_t     fetch_response;
  mem_tag_t     data_response;
  cache_index_t current_index;
  cache_tag_t   current_tag;
  logic         data_write_enable;
  logic         cachemem_valid;

  assign fetch_data = cachemem_data;  // the fetched word comes straight from storage.

  icache_ctrl u_icache_ctrl (
    .clock             (clock),
    .reset             (reset),
    .fetch_addr        (fetch_addr),
    .mem_response      (fetch_response),
    .mem_tag           (mem_tag),
    .cachemem_valid    (cachemem_valid),
    .fetch_command     (fetch_command),
    .fetch_mem_addr    (fetch_mem_addr),
    .current_index     (current_index),
    .current_tag       (current_tag),
    .data_write_enable (data_write_enable),
    .fetch_valid       (fetch_valid)
  );

  icache_mem u_icache_mem (
    .clock             (clock),
    .reset             (reset),
    .current_index     (current_index),
    .current_tag       (current_tag),
    .data_write_enable (data_write_enable),
    .mem_data          (mem_data),
    .cachemem_data     (cachemem_data),
    .cachemem_valid    (cachemem_valid)
  );

  data_port u_data_port (
    .clock           (clock),
    .reset           (reset),
    .data_req        (data_req),
    .data_command_in (data_command_in),
    .data_addr       (data_addr),
    .data_wdata      (data_wdata),
    .data_response   (data_response),
    .mem_tag         (mem_tag),
    .mem_data        (mem_data),
    .data_command    (data_command),
    .data_mem_addr   (data_mem_addr),
    .data_mem_wdata  (data_mem_wdata),
    .data_rdata      (data_rdata),
    .data_done       (data_done)
  );

  bus_arbiter u_bus_arbiter (
    .fetch_command  (fetch_command),
    .fetch_mem_addr (fetch_mem_addr),
    .data_command   (data_command),
    .data_mem_addr  (data_mem_addr),
    .data_mem_wdata (data_mem_wdata),
    .mem_response   (mem_response),
    .mem_command    (mem_command),
    .mem_addr       (mem_addr),
    .mem_wdata      (mem_wdata),
    .fetch_response (fetch_response),
    .data_response  (data_response)
  );

endmodule

`default_nettype wire

// File: tb_mem_model.sv
`default_nettype none

`include "mem_cfg.svh"

module tb_mem_model (
  input  wire logic                  clock,
  input  wire logic                  reset,
  input  wire bus_pkg::bus_command_t mem_command,
  input  wire bus_pkg::addr_t        mem_addr,
  input  wire bus_pkg::word_t        mem_wdata,
  output bus_pkg::mem_tag_t          mem_response,
  output bus_pkg::mem_tag_t          mem_tag,
  output bus_pkg::word_t             mem_data
);

  import bus_pkg::*;

  localparam int num_tags = 1 << `MEM_TAG_W;

  integer              seed;
  word_t               words [256];
  addr_t               tag_addr [num_tags];
  logic [3:0]          countdown [num_tags];
  logic [num_tags-1:0] busy;
  logic                refuse;
  mem_tag_t            free_tag;
  int                  refusal_count;

  initial begin
    seed = 32'h8dae_9739;
    for (int i = 0; i < 256; i++) begin
      words[i] = (word_t'(i) << 3) ^ 64'h5a3c_96e1_0f87_d2b4;  // same fill as the testbench copy.
    end
    busy          = '0;
    refuse        = 1'b0;
    mem_tag       = '0;
    mem_data      = '0;
    refusal_count = 0;
  end

  // lowest free tag, zero when all of them are in flight.
  always_comb begin
    free_tag = '0;
    for (int t = num_tags - 1; t > 0; t--) begin
      if (!busy[t]) begin
        free_tag = mem_tag_t'(t);
      end
    end
    mem_response = (mem_command != bus_none && !refuse) ? free_tag : '0;
  end

  always @(posedge clock) begin
    logic sent;
    sent = 1'b0;
    mem_tag <= '0;
    refuse  <= (($random(seed) & 3) == 0);  // about one command in four is refused.
    if (reset) begin
      busy <= '0;
    end else begin
      for (int t = 1; t < num_tags; t++) begin
        if (busy[t]) begin
          if (countdown[t] > 4'd1) begin
            countdown[t] <= countdown[t] - 4'd1;
          end else if (!sent) begin
            sent = 1'b1;
            mem_tag  <= mem_tag_t'(t);
            mem_data <= words[tag_addr[t][10:3]];
            busy[t]  <= 1'b0;
          end
        end
      end
      if (mem_command != bus_none) begin
        if (mem_response == '0) begin
          refusal_count <= refusal_count + 1;
        end else if (mem_command == bus_store) begin
          words[mem_addr[10:3]] <= mem_wdata;
        end else begin
          busy[mem_response]      <= 1'b1;
          countdown[mem_response] <= 4'(2 + ($random(seed) & 7));
          tag_addr[mem_response]  <= mem_addr;
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: tb_fetch_mem.sv
`default_nettype none

`include "mem_cfg.svh"

module tb_fetch_mem;

  import bus_pkg::*;

  localparam int op_fetch      = 0;
  localparam int op_load       = 1;
  localparam int op_store      = 2;
  localparam int op_fetch_load = 3;
  localparam int num_entries   = 12;

  logic         clock;
  logic         reset;
  addr_t        fetch_addr;
  logic         data_req;
  bus_command_t data_command_in;
  addr_t        data_addr;
  word_t        data_wdata;
  mem_tag_t     mem_response;
  mem_tag_t     mem_tag;
  word_t        mem_data;
  word_t        fetch_data;
  logic         fetch_valid;
  word_t        data_rdata;
  logic         data_done;
  bus_command_t mem_command;
  addr_t        mem_addr;
  word_t        mem_wdata;

  int    entry_op [num_entries];
  addr_t entry_addr [num_entries];
  word_t entry_wdata [num_entries];
  addr_t entry_addr2 [num_entries];  // abandoned fetch, or the load beside a fetch.
  logic  entry_hit [num_entries];
  word_t ref_mem [256];
  int    error_count;
  int    failed_tests;

  fetch_mem_top u_fetch_mem_top (
    .clock(clock), .reset(reset), .fetch_addr(fetch_addr), .data_req(data_req),
    .data_command_in(data_command_in), .data_addr(data_addr), .data_wdata(data_wdata),
    .mem_response(mem_response), .mem_tag(mem_tag), .mem_data(mem_data),
    .fetch_data(fetch_data), .fetch_valid(fetch_valid), .data_rdata(data_rdata),
    .data_done(data_done), .mem_command(mem_command), .mem_addr(mem_addr),
    .mem_wdata(mem_wdata)
  );

  tb_mem_model u_mem_model (
    .clock(clock), .reset(reset), .mem_command(mem_command), .mem_addr(mem_addr),
    .mem_wdata(mem_wdata), .mem_response(mem_response), .mem_tag(mem_tag),
    .mem_data(mem_data)
  );

  always #20 clock = ~clock;

  initial begin
    #(num_entries * 40 * 40);
    $display("watchdog expired before all tests finished");
    $display("*** TEST FAILED ***");
    $finish;
  end

  task automatic check_word(input word_t actual, input word_t expected, input string what);
    if (actual !== expected) begin
      error_count++;
      $display("CHECK FAILED at %0t: %s expected %h got %h", $time, what, expected, actual);
    end
  endtask

  task automatic check_flag(input logic actual, input logic expected, input string what);
    if (actual !== expected) begin
      error_count++;
      $display("CHECK FAILED at %0t: %s expected %b got %b", $time, what, expected, actual);
    end
  endtask

  task automatic add_entry(input int idx, input int op, input addr_t addr,
                           input word_t wdata, input addr_t addr2, input logic hit);
    entry_op[idx]    = op;
    entry_addr[idx]  = addr;
    entry_wdata[idx] = wdata;
    entry_addr2[idx] = addr2;
    entry_hit[idx]   = hit;
  endtask

  // called on a falling edge, so every input it drives is settled by the rising edge.
  task automatic run_entry(input int idx);
    logic fetch_seen;
    logic data_seen;
    logic want_fetch;
    logic want_data;
    want_fetch = (entry_op[idx] == op_fetch) || (entry_op[idx] == op_fetch_load);
    want_data  = (entry_op[idx] != op_fetch);
    fetch_seen = !want_fetch;
    data_seen  = !want_data;
    if (entry_op[idx] == op_fetch && entry_addr2[idx] != '0) begin
      fetch_addr = entry_addr2[idx];
      repeat (2) @(negedge clock);  // the first miss is still in flight here.
    end
    if (want_fetch) begin
      fetch_addr = entry_addr[idx];
    end
    if (want_data) begin
      data_req        = 1'b1;
      data_command_in = (entry_op[idx] == op_store) ? bus_store : bus_load;
      data_addr       = (entry_op[idx] == op_fetch_load) ? entry_addr2[idx] : entry_addr[idx];
      data_wdata      = entry_wdata[idx];
    end
    if (entry_hit[idx]) begin
      #1;
      check_flag(fetch_valid, 1'b1, "fetch hit in the same cycle");
      check_word(fetch_data, ref_mem[entry_addr[idx][10:3]], "fetch hit data");
      repeat (3) begin
        @(negedge clock);
        check_flag(mem_command == bus_none, 1'b1, "bus idle during hit");
      end
      fetch_seen = 1'b1;
    end
    while (!(fetch_seen && data_seen)) begin
      @(negedge clock);
      if (!fetch_seen && fetch_valid) begin
        fetch_seen = 1'b1;
        check_word(fetch_data, ref_mem[entry_addr[idx][10:3]], "fetch data");
      end
      if (!data_seen && data_done) begin
        data_seen = 1'b1;
        if (data_command_in == bus_store) begin
          ref_mem[data_addr[10:3]] = data_wdata;
        end else begin
          check_word(data_rdata, ref_mem[data_addr[10:3]], "load data");
        end
        data_req        = 1'b0;
        data_command_in = bus_none;
      end
    end
  endtask

  initial begin
    int errors_before;
    clock           = 1'b0;
    reset           = 1'b1;
    fetch_addr      = '0;
    data_req        = 1'b0;
    data_command_in = bus_none;
    data_addr       = '0;
    data_wdata      = '0;
    error_count     = 0;
    failed_tests    = 0;
    for (int i = 0; i < 256; i++) begin
      ref_mem[i] = (word_t'(i) << 3) ^ 64'h5a3c_96e1_0f87_d2b4;
    end
    add_entry(0, op_fetch, 64'h040, '0, '0, 1'b0);       // cold miss.
    add_entry(1, op_fetch, 64'h040, '0, '0, 1'b1);
    add_entry(2, op_fetch, 64'h140, '0, '0, 1'b0);       // same index, other tag.
    add_entry(3, op_fetch, 64'h040, '0, '0, 1'b0);
    add_entry(4, op_fetch, 64'h5a8, '0, 64'h208, 1'b0);  // 0x208 is abandoned.
    add_entry(5, op_fetch, 64'h208, '0, '0, 1'b0);
    add_entry(6, op_fetch_load, 64'h088, '0, 64'h310, 1'b0);
    add_entry(7, op_store, 64'h318, 64'hdead_beef_0123_4567, '0, 1'b0);
    add_entry(8, op_load, 64'h318, '0, '0, 1'b0);
    add_entry(9, op_load, 64'h7f8, '0, '0, 1'b0);
    add_entry(10, op_fetch, 64'h040, '0, '0, 1'b1);      // moves back to a cached line.
    add_entry(11, op_fetch_load, 64'h0c0, '0, 64'h318, 1'b0);
    repeat (16) @(negedge clock);
    reset = 1'b0;
    for (int i = 0; i < num_entries; i++) begin
      errors_before = error_count;
      @(negedge clock);
      run_entry(i);
      if (error_count != errors_before) begin
        failed_tests++;
      end
      $display("test %0d op %0d addr %h: %s", i, entry_op[i], entry_addr[i],
               (error_count == errors_before) ? "ok" : "error");
    end
    check_flag(u_mem_model.refusal_count > 0, 1'b1, "refusals seen on the bus");
    $display("tests run %0d, tests failed %0d, checks failed %0d",
             num_entries, failed_tests, error_count);
    if (error_count == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: files.f
+incdir+.
bus_pkg.sv
icache_pkg.sv
icache_ctrl.sv
icache_mem.sv
bus_arbiter.sv
data_port.sv
fetch_mem_top.sv
tb_mem_model.sv
tb_fetch_mem.sv

// File: Makefile
.PHONY: all run lint clean

all: run

obj_dir/Vtb_fetch_mem: files.f *.sv mem_cfg.svh
	verilator --binary --timing --assert -j 0 -f files.f --top-module tb_fetch_mem

run: obj_dir/Vtb_fetch_mem
	./obj_dir/Vtb_fetch_mem | tee sim.log
	@grep -q "\*\*\* TEST PASSED \*\*\*" sim.log

lint:
	verilator --lint-only --timing -f files.f --top-module tb_fetch_mem

clean:
	rm -rf obj_dir sim.log
